//--- pu.f
logic/pu_pkg.sv
logic/pu_regfile_if.sv
logic/pu_decode.sv
logic/pu_regfile.sv
logic/pu_alu.sv
logic/pu_imem.sv
logic/pu_control.sv
logic/pu_top.sv
tests/pu_tb.sv

//--- Makefile
# Verilator lint and simulation of the RV32I processing unit
VERILATOR ?= verilator
FILELIST  ?= pu.f
TB_TOP    ?= pu_tb
RTL_TOP   ?= pu_top
BUILD_DIR ?= build
LOG       ?= sim.log
VFLAGS    ?= --timing --assert

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(RTL_TOP)
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TB_TOP)

sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TB_TOP) \
		--Mdir $(BUILD_DIR) -o $(TB_TOP)
	./$(BUILD_DIR)/$(TB_TOP) | tee $(LOG)
	grep -q "Testbench passed" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- tests/pu_tb.sv
// Directed testbench for the RV32I processing unit
// Loads hand-assembled programs, runs them against a data memory model with
// random back-pressure and checks the stores seen on the request channel
module pu_tb
	import pu_pkg::*;
();
	timeunit 1ns;
	timeprecision 1ps;

	localparam int run_limit       = 2000; // Cycles allowed per program
	localparam int step_total      = 260;  // Loaded words plus executed instructions
	localparam int cycles_per_step = 4;
	localparam int max_stall       = 8;    // Longest ready or response delay
	localparam int watchdog_cycles = step_total * cycles_per_step * max_stall;
	localparam logic [xlen-1:0] ecall_word = {25'b0, op_system, 2'b11};

	logic                   clk = 1'b0;
	logic                   reset;
	logic                   start;
	logic                   busy;
	logic                   done;
	logic                   error;
	logic                   load_valid;
	logic                   load_ready;
	logic [imem_addr_w-1:0] load_addr;
	logic [xlen-1:0]        load_data;
	logic                   mem_req_valid;
	logic                   mem_req_ready;
	logic                   mem_req_write;
	logic [xlen-1:0]        mem_req_addr;
	logic [xlen-1:0]        mem_req_wdata;
	logic                   mem_rsp_valid;
	logic [xlen-1:0]        mem_rsp_rdata;

	logic [xlen-1:0] prog [$];
	logic [xlen-1:0] store_addr_q [$]; // Stores seen on the request channel
	logic [xlen-1:0] store_data_q [$];
	logic [xlen-1:0] exp_addr_q [$];
	logic [xlen-1:0] exp_data_q [$];
	logic [xlen-1:0] data_mem [256];
	logic [15:0]     lfsr = 16'd80;
	int              errors = 0;
	int              tests_passed = 0;
	int              tests_failed = 0;

	pu_top dut (.*);

	always #5 clk = ~clk;

	// ========================================
	// Random bits and instruction encoding
	// ========================================
	function automatic int random_bits(input int n);
		int v;
		int i;
		v = 0;
		for (i = 0; i < n; i++) begin
			v = (v << 1) | int'(lfsr[0]);
			lfsr = lfsr[0] ? ((lfsr >> 1) ^ 16'hB400) : (lfsr >> 1); // Galois step
		end
		return v;
	endfunction

	function automatic logic [xlen-1:0] enc_r(input int f7, rs2, rs1, f3, rd,
		input logic [4:0] op);
		return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], op, 2'b11};
	endfunction

	function automatic logic [xlen-1:0] enc_i(input int imm, rs1, f3, rd,
		input logic [4:0] op);
		return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], op, 2'b11};
	endfunction

	function automatic logic [xlen-1:0] enc_sw(input int imm, rs2, rs1);
		return {imm[11:5], rs2[4:0], rs1[4:0], 3'b010, imm[4:0], op_store, 2'b11};
	endfunction

	function automatic logic [xlen-1:0] enc_b(input int imm, rs2, rs1, f3);
		return {imm[12], imm[10:5], rs2[4:0], rs1[4:0], f3[2:0], imm[4:1], imm[11],
			op_branch, 2'b11};
	endfunction

	function automatic logic [xlen-1:0] enc_u(input int imm20, rd, input logic [4:0] op);
		return {imm20[19:0], rd[4:0], op, 2'b11};
	endfunction

	function automatic logic [xlen-1:0] enc_j(input int imm, rd);
		return {imm[20], imm[10:1], imm[11], imm[19:12], rd[4:0], op_jal, 2'b11};
	endfunction

	function automatic logic [xlen-1:0] enc_addi(input int rd, rs1, imm);
		return enc_i(imm, rs1, 0, rd, op_imm);
	endfunction

	// Reference branch rule straight from the ISA
	function automatic bit branch_expect(input int f3, input logic [xlen-1:0] a, b);
		case (f3)
			0:       return a == b;
			1:       return a != b;
			4:       return $signed(a) < $signed(b);
			5:       return $signed(a) >= $signed(b);
			6:       return a < b;
			default: return a >= b;
		endcase
	endfunction

	// ========================================
	// Checks and reporting
	// ========================================
	task automatic check_word(input string name, input logic [xlen-1:0] got, exp);
		if (got !== exp) begin
			$display("Error at %0t ns: %s is 0x%h, expected 0x%h", $time, name, got, exp);
			errors++;
		end
	endtask

	task automatic check_flag(input string name, input logic got, exp);
		if (got !== exp) begin
			$display("Error at %0t ns: %s is %b, expected %b", $time, name, got, exp);
			errors++;
		end
	endtask

	task automatic check_stores();
		int i;
		if (store_addr_q.size() != exp_addr_q.size()) begin
			$display("The program made %0d stores where %0d were expected",
				store_addr_q.size(), exp_addr_q.size());
			errors++;
		end
		for (i = 0; i < exp_addr_q.size() && i < store_addr_q.size(); i++) begin
			check_word("mem_req_addr", store_addr_q[i], exp_addr_q[i]);
			check_word("mem_req_wdata", store_data_q[i], exp_data_q[i]);
		end
	endtask

	task automatic finish_test(input string name, input int errors_before);
		if (errors == errors_before) begin
			$display("%s: ok", name);
			tests_passed++;
		end else begin
			$display("%s: %0d errors", name, errors - errors_before);
			tests_failed++;
		end
	endtask

	task automatic begin_program();
		prog.delete();
		exp_addr_q.delete();
		exp_data_q.delete();
	endtask

	task automatic expect_store(input logic [xlen-1:0] addr, data);
		exp_addr_q.push_back(addr);
		exp_data_q.push_back(data);
	endtask

	// Load, start, wait for done, then check flags and stores
	task automatic run_and_check(input logic exp_error);
		int i;
		int cycles;
		for (i = 0; i < prog.size(); i++) begin
			load_valid = 1'b1;
			load_addr  = imem_addr_w'(i);
			load_data  = prog[i];
			@(posedge clk);
			while (!load_ready) @(posedge clk);
			#1;
		end
		load_valid = 1'b0;
		store_addr_q.delete();
		store_data_q.delete();
		start = 1'b1;
		@(posedge clk);
		#1;
		start  = 1'b0;
		cycles = 0;
		while (!done && cycles < run_limit) begin
			@(posedge clk);
			#1;
			cycles++;
		end
		if (!done) begin
			$display("Program did not reach done within %0d cycles", run_limit);
			errors++;
		end
		check_flag("done", done, 1'b1);
		check_flag("busy", busy, 1'b0);
		check_flag("error", error, exp_error);
		check_stores();
	endtask

	// ========================================
	// Tests
	// ========================================
	task automatic test_reset_state();
		int errors_before;
		errors_before = errors;
		check_flag("busy", busy, 1'b0);
		check_flag("done", done, 1'b0);
		check_flag("error", error, 1'b0);
		check_flag("load_ready", load_ready, 1'b1);
		check_flag("mem_req_valid", mem_req_valid, 1'b0);
		finish_test("reset state", errors_before);
	endtask

	task automatic test_arith();
		int              errors_before;
		int              k;
		logic [xlen-1:0] a;
		logic [xlen-1:0] b;
		logic [xlen-1:0] res [11];
		errors_before = errors;
		begin_program();
		a = -7;
		b = 12;
		prog.push_back(enc_addi(1, 0, -7));
		prog.push_back(enc_addi(2, 0, 12));
		prog.push_back(enc_r(0, 2, 1, 0, 3, op_r));     // add
		prog.push_back(enc_r(32, 2, 1, 0, 4, op_r));    // sub
		prog.push_back(enc_r(0, 2, 1, 4, 5, op_r));     // xor
		prog.push_back(enc_r(0, 2, 1, 6, 6, op_r));     // or
		prog.push_back(enc_r(0, 2, 1, 7, 7, op_r));     // and
		prog.push_back(enc_r(0, 4, 2, 1, 8, op_imm));   // slli by 4
		prog.push_back(enc_r(0, 4, 1, 5, 9, op_imm));   // srli by 4
		prog.push_back(enc_r(32, 1, 1, 5, 10, op_imm)); // srai by 1
		prog.push_back(enc_r(0, 2, 1, 2, 11, op_r));    // slt
		prog.push_back(enc_r(0, 2, 1, 3, 12, op_r));    // sltu
		for (k = 0; k < 11; k++) begin
			prog.push_back(enc_sw(256 + 4 * k, (k == 0) ? 1 : k + 2, 0));
		end
		prog.push_back(ecall_word);
		res[0]  = a;
		res[1]  = a + b;
		res[2]  = a - b;
		res[3]  = a ^ b;
		res[4]  = a | b;
		res[5]  = a & b;
		res[6]  = b << 4;
		res[7]  = a >> 4;
		res[8]  = $signed(a) >>> 1;
		res[9]  = {31'b0, $signed(a) < $signed(b)};
		res[10] = {31'b0, a < b};
		for (k = 0; k < 11; k++) expect_store(xlen'(256 + 4 * k), res[k]);
		run_and_check(1'b0);
		finish_test("arithmetic", errors_before);
	endtask

	task automatic test_upper_jump();
		int errors_before;
		errors_before = errors;
		begin_program();
		prog.push_back(enc_u(32'h12345, 1, op_lui));   // pc 0
		prog.push_back(enc_u(32'h00001, 2, op_auipc)); // pc 4
		prog.push_back(enc_j(12, 3));                  // pc 8 jumps to 20
		prog.push_back(enc_sw(32'h1F0, 1, 0));         // Skipped
		prog.push_back(enc_sw(32'h1F0, 1, 0));         // Skipped
		prog.push_back(enc_addi(4, 0, 41));            // pc 20, odd target
		prog.push_back(enc_i(0, 4, 0, 5, op_jalr));    // pc 24 jumps to 40
		repeat (3) prog.push_back(enc_sw(32'h1F4, 1, 0));
		prog.push_back(enc_sw(32'h100, 1, 0));         // pc 40
		prog.push_back(enc_sw(32'h104, 2, 0));
		prog.push_back(enc_sw(32'h108, 3, 0));
		prog.push_back(enc_sw(32'h10C, 5, 0));
		prog.push_back(ecall_word);
		expect_store(32'h100, 32'h12345 << 12);
		expect_store(32'h104, 32'd4 + (32'h1 << 12));
		expect_store(32'h108, 32'd8 + 32'd4);  // jal link
		expect_store(32'h10C, 32'd24 + 32'd4); // jalr link
		run_and_check(1'b0);
		finish_test("upper immediates and jumps", errors_before);
	endtask

	task automatic test_branches();
		int              errors_before;
		int              k;
		int              f3_tab [12]  = '{0, 0, 1, 1, 4, 4, 5, 5, 6, 6, 7, 7};
		int              rs1_tab [12] = '{2, 1, 1, 2, 1, 2, 2, 1, 2, 1, 1, 2};
		int              rs2_tab [12] = '{3, 2, 2, 3, 2, 1, 1, 2, 1, 2, 2, 1};
		logic [xlen-1:0] vals [4];
		errors_before = errors;
		begin_program();
		vals[0] = 0;
		vals[1] = -3;
		vals[2] = 5;
		vals[3] = 5;
		prog.push_back(enc_addi(1, 0, -3));
		prog.push_back(enc_addi(2, 0, 5));
		prog.push_back(enc_addi(3, 0, 5));
		for (k = 0; k < 12; k++) begin
			prog.push_back(enc_b(8, rs2_tab[k], rs1_tab[k], f3_tab[k])); // Taken skips the store
			prog.push_back(enc_sw(256 + 4 * k, 1, 0));
			if (!branch_expect(f3_tab[k], vals[rs1_tab[k]], vals[rs2_tab[k]])) begin
				expect_store(xlen'(256 + 4 * k), vals[1]);
			end
		end
		// Countdown from 5 with an iteration counter
		prog.push_back(enc_addi(4, 0, 5));
		prog.push_back(enc_addi(5, 0, 0));
		prog.push_back(enc_addi(5, 5, 1));
		prog.push_back(enc_addi(4, 4, -1));
		prog.push_back(enc_b(-8, 0, 4, 1));
		prog.push_back(enc_sw(32'h140, 4, 0));
		prog.push_back(enc_sw(32'h144, 5, 0));
		prog.push_back(ecall_word);
		expect_store(32'h140, 32'd0);
		expect_store(32'h144, 32'd5);
		run_and_check(1'b0);
		finish_test("branches", errors_before);
	endtask

	task automatic test_memory();
		int              errors_before;
		logic [xlen-1:0] v;
		errors_before = errors;
		begin_program();
		v = -1234;
		prog.push_back(enc_addi(1, 0, -1234));
		prog.push_back(enc_sw(32'h200, 1, 0));
		prog.push_back(enc_i(32'h200, 0, 2, 2, op_load));
		prog.push_back(enc_addi(3, 2, 1));
		prog.push_back(enc_sw(32'h204, 3, 0));
		prog.push_back(enc_i(32'h204, 0, 2, 4, op_load));
		prog.push_back(enc_addi(5, 4, 1));
		prog.push_back(enc_sw(32'h208, 5, 0));
		prog.push_back(ecall_word);
		expect_store(32'h200, v);
		expect_store(32'h204, v + 1);
		expect_store(32'h208, v + 2);
		run_and_check(1'b0);
		finish_test("memory under back-pressure", errors_before);
	endtask

	task automatic test_termination();
		int              errors_before;
		int              t;
		logic [xlen-1:0] end_word [4];
		logic            end_error [4];
		errors_before = errors;
		end_word[0]  = ecall_word;
		end_error[0] = 1'b0;
		end_word[1]  = 32'h0000007F;                     // Unknown opcode
		end_error[1] = 1'b1;
		end_word[2]  = enc_b(8, 0, 0, 2);               // Branch funct3 010
		end_error[2] = 1'b1;
		end_word[3]  = enc_i(32'h300, 0, 0, 2, op_load); // lb
		end_error[3] = 1'b1;
		for (t = 0; t < 4; t++) begin
			begin_program();
			prog.push_back(enc_addi(1, 0, 20 + t));
			prog.push_back(enc_sw(32'h300, 1, 0));
			prog.push_back(end_word[t]);
			prog.push_back(enc_sw(32'h304, 1, 0)); // Never reached
			prog.push_back(ecall_word);
			expect_store(32'h300, xlen'(20 + t));
			run_and_check(end_error[t]);
		end
		finish_test("termination", errors_before);
	endtask

	// ========================================
	// Data memory model
	// ========================================
	initial begin : data_memory_model
		logic            req_fire;
		logic            rsp_pending;
		int              rsp_wait;
		logic [xlen-1:0] rsp_word;
		int              i;
		mem_req_ready = 1'b0;
		mem_rsp_valid = 1'b0;
		mem_rsp_rdata = '0;
		rsp_pending   = 1'b0;
		rsp_wait      = 0;
		rsp_word      = '0;
		for (i = 0; i < 256; i++) data_mem[i] = 32'hDA7A0000 | xlen'(i << 2);
		forever begin
			@(posedge clk);
			req_fire = mem_req_valid && mem_req_ready;
			if (req_fire && mem_req_write) begin
				data_mem[mem_req_addr[9:2]] = mem_req_wdata;
				store_addr_q.push_back(mem_req_addr);
				store_data_q.push_back(mem_req_wdata);
			end else if (req_fire) begin
				rsp_pending = 1'b1;
				rsp_word    = data_mem[mem_req_addr[9:2]];
				rsp_wait    = random_bits(2); // Up to 3 extra cycles
			end
			#1;
			mem_rsp_valid = 1'b0;
			if (reset) begin
				rsp_pending = 1'b0;
			end else if (rsp_pending && rsp_wait == 0) begin
				mem_rsp_valid = 1'b1;
				mem_rsp_rdata = rsp_word;
				rsp_pending   = 1'b0;
			end else if (rsp_pending) begin
				rsp_wait--;
			end
			mem_req_ready = (random_bits(2) != 0); // Stall one cycle in four
		end
	end

	// Watchdog
	initial begin
		repeat (watchdog_cycles) @(posedge clk);
		$display("Watchdog expired after %0d cycles", watchdog_cycles);
		$display("Testbench failed");
		$finish;
	end

	initial begin
		reset      = 1'b1;
		start      = 1'b0;
		load_valid = 1'b0;
		load_addr  = '0;
		load_data  = '0;
		repeat (3) @(posedge clk);
		#1;
		reset = 1'b0;
		test_reset_state();
		test_arith();
		test_upper_jump();
		test_branches();
		test_memory();
		test_termination();
		$display("Tests passed %0d, failed %0d, errors %0d", tests_passed, tests_failed, errors);
		if (tests_failed == 0 && errors == 0) begin
			$display("Testbench passed");
		end else begin
			$display("Testbench failed");
		end
		$finish;
	end

endmodule

//--- logic/pu_top.sv
// Top level of the RV32I processing unit
// Load a program over the load port, pulse start, then wait for done
// Data memory sits outside, on the request and response ports
module pu_top
	import pu_pkg::*;
(
	input  logic                   clk,
	input  logic                   reset,
	input  logic                   start,
	output logic                   busy,
	output logic                   done,
	output logic                   error,
	input  logic                   load_valid,
	output logic                   load_ready,
	input  logic [imem_addr_w-1:0] load_addr,
	input  logic [xlen-1:0]        load_data,
	output logic                   mem_req_valid,
	input  logic                   mem_req_ready,
	output logic                   mem_req_write,
	output logic [xlen-1:0]        mem_req_addr,
	output logic [xlen-1:0]        mem_req_wdata,
	input  logic                   mem_rsp_valid,
	input  logic [xlen-1:0]        mem_rsp_rdata
);

	logic [imem_addr_w-1:0] fetch_addr;
	logic [xlen-1:0]        fetch_data;
	dec_type                dec_cmd;
	logic [xlen-1:0]        alu_a;
	logic [xlen-1:0]        alu_b;
	logic [xlen-1:0]        alu_result;
	logic                   branch_taken;

	pu_regfile_if rf_bus ();

	pu_imem u_imem (
		.clk        (clk),
		.load_valid (load_valid),
		.load_addr  (load_addr),
		.load_data  (load_data),
		.load_ready (load_ready),
		.fetch_addr (fetch_addr),
		.fetch_data (fetch_data)
	);

	pu_decode u_decode (
		.inst    (fetch_data),
		.dec_cmd (dec_cmd)
	);

	pu_control u_control (
		.clk           (clk),
		.reset         (reset),
		.start         (start),
		.busy          (busy),
		.done          (done),
		.error         (error),
		.load_ready    (load_ready),
		.fetch_addr    (fetch_addr),
		.fetch_data    (fetch_data),
		.dec_cmd       (dec_cmd),
		.rf            (rf_bus.ctrl),
		.alu_a         (alu_a),
		.alu_b         (alu_b),
		.alu_result    (alu_result),
		.branch_taken  (branch_taken),
		.mem_req_valid (mem_req_valid),
		.mem_req_ready (mem_req_ready),
		.mem_req_write (mem_req_write),
		.mem_req_addr  (mem_req_addr),
		.mem_req_wdata (mem_req_wdata),
		.mem_rsp_valid (mem_rsp_valid),
		.mem_rsp_rdata (mem_rsp_rdata)
	);

	pu_regfile u_regfile (
		.clk (clk),
		.rf  (rf_bus.rf)
	);

	pu_alu u_alu (
		.a            (alu_a),
		.b            (alu_b),
		.dec_cmd      (dec_cmd),
		.result       (alu_result),
		.branch_taken (branch_taken)
	);

endmodule

//--- logic/pu_control.sv
// Control FSM of the processing unit
// Holds the PC, steps each instruction through fetch, execute and memory phases,
// picks ALU operands and writeback data and runs the data memory handshake
module pu_control
	import pu_pkg::*;
(
	input  logic                   clk,
	input  logic                   reset,
	input  logic                   start,
	output logic                   busy,
	output logic                   done,
	output logic                   error,
	output logic                   load_ready,
	output logic [imem_addr_w-1:0] fetch_addr,
	input  logic [xlen-1:0]        fetch_data,
	input  dec_type                dec_cmd,
	pu_regfile_if.ctrl             rf,
	output logic [xlen-1:0]        alu_a,
	output logic [xlen-1:0]        alu_b,
	input  logic [xlen-1:0]        alu_result,
	input  logic                   branch_taken,
	output logic                   mem_req_valid,
	input  logic                   mem_req_ready,
	output logic                   mem_req_write,
	output logic [xlen-1:0]        mem_req_addr,
	output logic [xlen-1:0]        mem_req_wdata,
	input  logic                   mem_rsp_valid,
	input  logic [xlen-1:0]        mem_rsp_rdata
);

	logic [2:0]      state;
	logic [2:0]      state_next;
	logic [xlen-1:0] pc;
	logic [xlen-1:0] pc_plus4;
	logic [xlen-1:0] pc_next;
	logic            wb_class;
	logic            idle;
	inst_word_u      inst_reg; // Keeps rd of a load across the memory phases

	assign idle       = (state == st_idle) || (state == st_done);
	assign busy       = !idle;
	assign done       = (state == st_done);
	assign load_ready = idle;
	assign fetch_addr = pc[imem_addr_w+1:2];
	assign pc_plus4   = pc + xlen'(4);
	assign wb_class   = dec_cmd.op || dec_cmd.opi || dec_cmd.lui || dec_cmd.auipc ||
		dec_cmd.jal || dec_cmd.jalr;

	// ========================================
	// Operands, next PC and writeback
	// ========================================
	assign rf.rs1_addr = dec_cmd.use_rs1 ? dec_cmd.rs1 : 5'd0;
	assign rf.rs2_addr = dec_cmd.use_rs2 ? dec_cmd.rs2 : 5'd0;
	assign alu_a = dec_cmd.lui ? '0 : ((dec_cmd.auipc || dec_cmd.jal) ? pc : rf.rs1_data);
	assign alu_b = dec_cmd.use_imm ? dec_cmd.imm : rf.rs2_data;

	always_comb begin
		if (dec_cmd.jal) pc_next = alu_result;
		else if (dec_cmd.jalr) pc_next = {alu_result[xlen-1:1], 1'b0};
		else if (branch_taken) pc_next = pc + dec_cmd.imm;
		else pc_next = pc_plus4;
	end

	always_comb begin
		rf.rd_addr = dec_cmd.rd;
		rf.rd_data = (dec_cmd.jal || dec_cmd.jalr) ? pc_plus4 : alu_result; // Link value
		rf.rd_we   = (state == st_execute) && wb_class && !dec_cmd.exception;
		if (state == st_mem_rsp) begin
			rf.rd_addr = inst_reg.r_view.rd;
			rf.rd_data = mem_rsp_rdata;
			rf.rd_we   = mem_rsp_valid;
		end
	end

	// ========================================
	// FSM
	// ========================================
	always_comb begin
		state_next = state;
		case (state)
			st_idle, st_done: if (start) state_next = st_fetch;
			st_fetch:         state_next = st_execute;
			st_execute: begin
				if (dec_cmd.exception || dec_cmd.end_program) state_next = st_done;
				else if (dec_cmd.load || dec_cmd.store) state_next = st_mem_req;
				else state_next = st_fetch;
			end
			st_mem_req: begin
				if (mem_req_ready) state_next = mem_req_write ? st_fetch : st_mem_rsp;
			end
			st_mem_rsp: if (mem_rsp_valid) state_next = st_fetch;
			default:    state_next = st_idle;
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			state         <= st_idle;
			pc            <= '0;
			error         <= 1'b0;
			mem_req_valid <= 1'b0;
		end else begin
			state <= state_next;
			case (state)
				st_idle, st_done: begin
					if (start) begin // New run from address 0
						pc    <= '0;
						error <= 1'b0;
					end
				end
				st_execute: begin
					if (dec_cmd.exception) begin
						error <= 1'b1;
					end else if (!dec_cmd.end_program) begin
						pc            <= pc_next;
						mem_req_valid <= dec_cmd.load || dec_cmd.store;
					end
				end
				st_mem_req: if (mem_req_ready) mem_req_valid <= 1'b0;
				default: ;
			endcase
		end
	end

	// Request payload, captured when the instruction executes
	always_ff @(posedge clk) begin
		if (state == st_execute) begin
			inst_reg      <= fetch_data;
			mem_req_write <= dec_cmd.store;
			mem_req_addr  <= alu_result;
			mem_req_wdata <= rf.rs2_data;
		end
	end

	a_req_hold: assert property (@(posedge clk) disable iff (reset)
		mem_req_valid && !mem_req_ready |=>
		mem_req_valid && $stable({mem_req_write, mem_req_addr, mem_req_wdata}))
		else $error("data memory request dropped or changed before ready");

	// PC returns to 0 while running only through a jump or taken branch
	a_start_ignored: assert property (@(posedge clk) disable iff (reset)
		start && busy |=> !(pc == '0 && $past(pc) != '0 &&
		!$past(dec_cmd.jal || dec_cmd.jalr || branch_taken)))
		else $error("start disturbed a running program");

endmodule

//--- logic/pu_imem.sv
// Word-addressed instruction memory
// Filled through the load port while idle, read by the fetch port one cycle later
module pu_imem
	import pu_pkg::*;
(
	input  logic                   clk,
	input  logic                   load_valid,
	input  logic [imem_addr_w-1:0] load_addr,
	input  logic [xlen-1:0]        load_data,
	input  logic                   load_ready,
	input  logic [imem_addr_w-1:0] fetch_addr,
	output logic [xlen-1:0]        fetch_data
);

	logic [xlen-1:0] mem [imem_depth];

	// Program load
	always_ff @(posedge clk) begin
		if (load_valid && load_ready) begin
			mem[load_addr] <= load_data;
		end
	end

	// Registered fetch read
	always_ff @(posedge clk) begin
		fetch_data <= mem[fetch_addr];
	end

endmodule

//--- logic/pu_alu.sv
// Integer ALU for RV32I register, immediate and address arithmetic
// Also resolves the branch condition from the compare result
module pu_alu
	import pu_pkg::*;
(
	input  logic [xlen-1:0] a,
	input  logic [xlen-1:0] b,
	input  dec_type         dec_cmd,
	output logic [xlen-1:0] result,
	output logic            branch_taken
);

	logic [2:0]      fn;
	logic            alt;
	logic [4:0]      shamt;
	logic [xlen-1:0] sra_res;

	// Loads, stores, jumps and upper immediates all use add
	assign fn = (dec_cmd.op || dec_cmd.opi || dec_cmd.branch) ? dec_cmd.funct3 : 3'b000;
	assign alt = dec_cmd.op ? dec_cmd.funct7[5] :
		((dec_cmd.opi || dec_cmd.branch) && dec_cmd.funct5[3]);
	assign shamt   = b[4:0];
	assign sra_res = $signed(a) >>> shamt;

	always_comb begin
		case (fn)
			3'b000:  result = alt ? a - b : a + b;
			3'b001:  result = a << shamt;
			3'b010:  result = {{(xlen-1){1'b0}}, $signed(a) < $signed(b)};
			3'b011:  result = {{(xlen-1){1'b0}}, a < b};
			3'b100:  result = a ^ b;
			3'b101:  result = alt ? sra_res : a >> shamt;
			3'b110:  result = a | b;
			default: result = a & b;
		endcase
	end

	// ========================================
	// Branch resolution
	// ========================================
	assign branch_taken = dec_cmd.branch && (dec_cmd.take_branch == (result == '0));

endmodule

//--- logic/pu_regfile.sv
// 32 x 32 integer register file
// Two combinational reads and one write per clock, x0 always reads as zero
module pu_regfile
	import pu_pkg::*;
(
	input logic        clk,
	pu_regfile_if.rf   rf
);

	logic [xlen-1:0] regs [32];

	always_ff @(posedge clk) begin
		if (rf.rd_we && rf.rd_addr != 5'd0) begin // x0 is never written
			regs[rf.rd_addr] <= rf.rd_data;
		end
	end

	// ========================================
	// Read ports
	// ========================================
	assign rf.rs1_data = (rf.rs1_addr == 5'd0) ? '0 : regs[rf.rs1_addr];
	assign rf.rs2_data = (rf.rs2_addr == 5'd0) ? '0 : regs[rf.rs2_addr];

	// Writeback data comes from ALU, PC or load response
	a_wb_known: assert property (@(posedge clk) rf.rd_we |-> !$isunknown(rf.rd_data))
		else $error("register write with unknown data");

endmodule

//--- logic/pu_decode.sv
// Combinational RV32I decoder
// Turns the fetched instruction word into the decoded command used by control and ALU
module pu_decode
	import pu_pkg::*;
(
	input  logic [xlen-1:0] inst,
	output dec_type         dec_cmd
);

	inst_word_u      iw;
	logic [4:0]      opcode;
	logic [xlen-1:0] imm_i;
	logic [xlen-1:0] imm_s;
	logic [xlen-1:0] imm_b;
	logic [xlen-1:0] imm_u;
	logic [xlen-1:0] imm_j;

	assign iw     = inst;
	assign opcode = iw.r_view.opcode[6:2];

	// ========================================
	// Immediate formats
	// ========================================
	assign imm_i = {{20{iw.i_view.imm_hi12[11]}}, iw.i_view.imm_hi12};
	assign imm_s = {{20{iw.i_view.imm_hi12[11]}}, iw.i_view.imm_hi12[11:5], iw.r_view.rd};
	assign imm_b = {{20{iw.r_view.funct7[6]}}, iw.r_view.rd[0], iw.r_view.funct7[5:0],
		iw.r_view.rd[4:1], 1'b0};
	assign imm_u = {inst[31:12], 12'b0};
	assign imm_j = {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};

	always_comb begin
		dec_cmd             = '0;
		dec_cmd.rs1         = iw.r_view.rs1;
		dec_cmd.rs2         = iw.r_view.rs2;
		dec_cmd.rd          = iw.r_view.rd;
		dec_cmd.funct3      = iw.r_view.funct3;
		dec_cmd.funct7      = iw.r_view.funct7;
		dec_cmd.funct5      = iw.r_view.funct7[6:2];
		dec_cmd.aq          = iw.r_view.funct7[1];
		dec_cmd.rl          = iw.r_view.funct7[0];
		dec_cmd.exception   = 1'b1; // Cleared by known opcodes
		if (iw.r_view.opcode[1:0] == 2'b11) begin
			case (opcode)
				op_r: begin
					dec_cmd.exception = 1'b0;
					dec_cmd.op        = 1'b1;
					dec_cmd.use_rs1   = 1'b1;
					dec_cmd.use_rs2   = 1'b1;
				end
				op_imm: begin
					dec_cmd.exception = 1'b0;
					dec_cmd.opi       = 1'b1;
					dec_cmd.use_imm   = 1'b1;
					dec_cmd.use_rs1   = 1'b1;
					if (iw.r_view.funct3 == 3'b001 || iw.r_view.funct3 == 3'b101) begin
						dec_cmd.imm = {27'b0, iw.r_view.rs2}; // Shift amount
					end else begin
						dec_cmd.imm    = imm_i;
						dec_cmd.funct5 = 5'b0;
					end
				end
				op_load: begin
					dec_cmd.exception = (iw.i_view.funct3 != 3'b010); // Word only
					dec_cmd.load      = 1'b1;
					dec_cmd.imm       = imm_i;
					dec_cmd.use_imm   = 1'b1;
					dec_cmd.use_rs1   = 1'b1;
					dec_cmd.funct5    = 5'b0;
				end
				op_store: begin
					dec_cmd.exception = (iw.i_view.funct3 != 3'b010);
					dec_cmd.store     = 1'b1;
					dec_cmd.imm       = imm_s;
					dec_cmd.use_imm   = 1'b1;
					dec_cmd.use_rs1   = 1'b1;
					dec_cmd.use_rs2   = 1'b1;
					dec_cmd.funct5    = 5'b0;
				end
				op_branch: begin
					dec_cmd.branch    = 1'b1;
					dec_cmd.imm       = imm_b;
					dec_cmd.use_rs1   = 1'b1;
					dec_cmd.use_rs2   = 1'b1;
					dec_cmd.exception = 1'b0;
					dec_cmd.funct5    = 5'b0;
					case (iw.r_view.funct3)
						3'b000: begin // beq
							dec_cmd.funct3      = 3'b000;
							dec_cmd.funct5      = 5'b01000;
							dec_cmd.take_branch = 1'b1;
						end
						3'b001: begin // bne
							dec_cmd.funct3 = 3'b000;
							dec_cmd.funct5 = 5'b01000;
						end
						3'b100: dec_cmd.funct3 = 3'b010; // blt
						3'b101: begin // bge
							dec_cmd.funct3      = 3'b010;
							dec_cmd.take_branch = 1'b1;
						end
						3'b110: dec_cmd.funct3 = 3'b011; // bltu
						3'b111: begin // bgeu
							dec_cmd.funct3      = 3'b011;
							dec_cmd.take_branch = 1'b1;
						end
						default: dec_cmd.exception = 1'b1;
					endcase
				end
				op_lui, op_auipc: begin
					dec_cmd.exception = 1'b0;
					dec_cmd.lui       = (opcode == op_lui);
					dec_cmd.auipc     = (opcode == op_auipc);
					dec_cmd.imm       = imm_u;
					dec_cmd.use_imm   = 1'b1;
					dec_cmd.funct3    = 3'b0;
					dec_cmd.funct5    = 5'b0;
				end
				op_jal: begin
					dec_cmd.exception = 1'b0;
					dec_cmd.jal       = 1'b1;
					dec_cmd.imm       = imm_j;
					dec_cmd.use_imm   = 1'b1;
					dec_cmd.funct3    = 3'b0;
					dec_cmd.funct5    = 5'b0;
				end
				op_jalr: begin
					dec_cmd.exception = 1'b0;
					dec_cmd.jalr      = 1'b1;
					dec_cmd.imm       = imm_i;
					dec_cmd.use_imm   = 1'b1;
					dec_cmd.use_rs1   = 1'b1;
					dec_cmd.funct5    = 5'b0;
				end
				op_atomic: begin
					dec_cmd.atomic  = 1'b1; // Fields kept, not executed
					dec_cmd.use_rs1 = 1'b1;
					dec_cmd.use_rs2 = 1'b1;
				end
				op_system: begin
					dec_cmd.exception   = 1'b0;
					dec_cmd.end_program = 1'b1;
				end
				default: dec_cmd.exception = 1'b1;
			endcase
		end
	end

endmodule

//--- logic/pu_regfile_if.sv
// Register file access bundle: two read ports and one write port
// The control side drives addresses and write data, the register file returns read data
interface pu_regfile_if
	import pu_pkg::*;
();

	logic [4:0]      rs1_addr;
	logic [4:0]      rs2_addr;
	logic [xlen-1:0] rs1_data;
	logic [xlen-1:0] rs2_data;
	logic [4:0]      rd_addr;
	logic [xlen-1:0] rd_data;
	logic            rd_we;

	modport ctrl (output rs1_addr, rs2_addr, rd_addr, rd_data, rd_we,
		input rs1_data, rs2_data);

	modport rf (input rs1_addr, rs2_addr, rd_addr, rd_data, rd_we,
		output rs1_data, rs2_data);

endinterface

//--- logic/pu_pkg.sv
// Shared sizes, opcodes, FSM encodings and instruction types for the RV32I unit
// Every block that handles instruction fields or data words imports this package
package pu_pkg;

	// ========================================
	// Sizes
	// ========================================
	localparam int xlen        = 32;
	localparam int imem_depth  = 256; // Words
	localparam int imem_addr_w = 8;   // Word address bits

	// ========================================
	// Opcodes, instruction bits 6 to 2
	// ========================================
	localparam logic [4:0] op_r      = 5'b01100;
	localparam logic [4:0] op_imm    = 5'b00100;
	localparam logic [4:0] op_load   = 5'b00000;
	localparam logic [4:0] op_store  = 5'b01000;
	localparam logic [4:0] op_branch = 5'b11000;
	localparam logic [4:0] op_lui    = 5'b01101;
	localparam logic [4:0] op_auipc  = 5'b00101;
	localparam logic [4:0] op_jal    = 5'b11011;
	localparam logic [4:0] op_jalr   = 5'b11001;
	localparam logic [4:0] op_system = 5'b11100;
	localparam logic [4:0] op_atomic = 5'b01011;

	// Control FSM states
	localparam logic [2:0] st_idle    = 3'd0;
	localparam logic [2:0] st_fetch   = 3'd1;
	localparam logic [2:0] st_execute = 3'd2;
	localparam logic [2:0] st_mem_req = 3'd3;
	localparam logic [2:0] st_mem_rsp = 3'd4;
	localparam logic [2:0] st_done    = 3'd5;

	typedef struct packed {
		logic [4:0]      rs1;
		logic [4:0]      rs2;
		logic [4:0]      rd;
		logic [2:0]      funct3;      // ALU operation for branches
		logic [6:0]      funct7;
		logic [4:0]      funct5;      // Bit 3 selects sub or sra
		logic            aq;
		logic            rl;
		logic [xlen-1:0] imm;
		logic            op;
		logic            opi;
		logic            jalr;
		logic            jal;
		logic            branch;
		logic            lui;
		logic            auipc;
		logic            store;
		logic            load;
		logic            atomic;
		logic            end_program;
		logic            use_imm;
		logic            take_branch; // Branch when compare is zero
		logic            use_rs1;
		logic            use_rs2;
		logic            exception;
	} dec_type;

	typedef struct packed {
		logic [6:0] funct7;
		logic [4:0] rs2;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [4:0] rd;
		logic [6:0] opcode;
	} r_view_t;

	typedef struct packed {
		logic [11:0] imm_hi12;
		logic [4:0]  rs1;
		logic [2:0]  funct3;
		logic [4:0]  rd;
		logic [6:0]  opcode;
	} i_view_t;

	typedef union packed {
		r_view_t r_view;
		i_view_t i_view;
	} inst_word_u;

endpackage
